/* design/spm_pkg.sv */
/*
 * spm package.
 * Sizes, address field positions and the request/response structs shared by
 * the requester side, the crossbar and the banked scratchpad memory.
 */

package spm_pkg;

  // system sizes.
  localparam int unsigned N_MASTERS  = 2;   // requesters sharing the memory.
  localparam int unsigned N_BANKS    = 4;   // word-interleaved banks.
  localparam int unsigned N_WORDS    = 64;  // words per bank.

  // data path.
  localparam int unsigned DATA_W     = 32;  // word width.
  localparam int unsigned BE_W       = 4;   // one enable per byte.
  localparam int unsigned ADDR_W     = 32;  // byte address from requesters.

  // requester id carried beside each bank access.
  localparam int unsigned ID_W       = 1;   // enough for N_MASTERS.

  // address split: [1:0] byte, [3:2] bank, [9:4] word index, rest ignored.
  localparam int unsigned BANK_SEL_W = 2;   // log2 of N_BANKS.
  localparam int unsigned WORD_IDX_W = 6;   // log2 of N_WORDS.
  localparam int unsigned BANK_LSB   = 2;   // first bank select bit.
  localparam int unsigned IDX_LSB    = 4;   // first word index bit.

  // request channel of one requester, held stable until gnt.
  typedef struct packed {
    logic              req;    // request valid.
    logic              we;     // 1 = write, 0 = read.
    logic [ADDR_W-1:0] addr;   // byte address.
    logic [BE_W-1:0]   be;     // byte enables for writes.
    logic [DATA_W-1:0] wdata;  // write data.
  } tcdm_req_t;                // 70 bits.

  // response channel back to one requester.
  typedef struct packed {
    logic              gnt;      // request accepted this cycle.
    logic              r_valid;  // answer to last cycle's accepted request.
    logic [DATA_W-1:0] r_data;   // read data, meaningful for reads only.
  } tcdm_rsp_t;                  // 34 bits.

  // request as it reaches one bank, after arbitration.
  typedef struct packed {
    logic                  req;    // winner present.
    logic                  we;     // write enable.
    logic [WORD_IDX_W-1:0] idx;    // word inside the bank.
    logic [BE_W-1:0]       be;     // byte enables.
    logic [DATA_W-1:0]     wdata;  // write data.
    logic [ID_W-1:0]       id;     // winning requester.
  } bank_req_t;

  // bank answer, one cycle after its request.
  typedef struct packed {
    logic              r_valid;  // request seen last cycle.
    logic [DATA_W-1:0] r_data;   // sram read data.
    logic [ID_W-1:0]   r_id;     // who asked.
  } bank_rsp_t;

endpackage : spm_pkg

/* design/spm_sram_bank.sv */
/*
 * spm sram bank.
 * Single-port byte-enabled word memory with one cycle of read latency.
 * Contents start as all ones; read data holds until the next read.
 */

module spm_sram_bank import spm_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  req_i,    // access this cycle.
  input  logic                  we_i,     // write when high.
  input  logic [WORD_IDX_W-1:0] idx_i,    // word index.
  input  logic [BE_W-1:0]       be_i,     // byte enables.
  input  logic [DATA_W-1:0]     wdata_i,  // write data.
  output logic [DATA_W-1:0]     rdata_o   // read data, one cycle later.
);

  logic [DATA_W-1:0] mem_q [N_WORDS];  // storage array.
  logic [DATA_W-1:0] rdata_q;          // registered read word.

  // unwritten words read back as all ones.
  initial begin
    for (int w = 0; w < N_WORDS; w++) begin
      mem_q[w] = '1;
    end
  end

  // byte-enabled write port.
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];  // enabled byte only.
        end
      end
    end
  end

  // read register, loaded on reads only.
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[idx_i];  // old value if written same edge, n/a here.
    end
  end

  assign rdata_o = rdata_q;

endmodule : spm_sram_bank

/* design/l1_spm.sv */
/*
 * l1 scratchpad memory.
 * N_BANKS single-port sram banks, each with a valid flag and a requester
 * id register so the crossbar can route the answer back. Banks never stall.
 */

module l1_spm import spm_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  bank_req_t [N_BANKS-1:0]   bank_req_i,  // arbitrated bank requests.
  output bank_rsp_t [N_BANKS-1:0]   bank_rsp_o   // answers, one cycle later.
);

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    logic              valid_q;  // a request was taken last cycle.
    logic [ID_W-1:0]   id_q;     // its requester.
    logic [DATA_W-1:0] rdata;    // sram output.

    // bookkeeping that travels beside the sram access.
    always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
        valid_q <= 1'b0;
        id_q    <= '0;
      end else begin
        valid_q <= bank_req_i[b].req;
        id_q    <= bank_req_i[b].id;  // only looked at when valid.
      end
    end

    spm_sram_bank i_sram_bank (
      .clk_i   ( clk_i               ),
      .rstn_i  ( rstn_i              ),
      .req_i   ( bank_req_i[b].req   ),
      .we_i    ( bank_req_i[b].we    ),
      .idx_i   ( bank_req_i[b].idx   ),
      .be_i    ( bank_req_i[b].be    ),
      .wdata_i ( bank_req_i[b].wdata ),
      .rdata_o ( rdata               )
    );

    // bank answer: flag, data and id line up in the same cycle.
    assign bank_rsp_o[b] = '{r_valid: valid_q, r_data: rdata, r_id: id_q};
  end

endmodule : l1_spm

/* design/spm_rr_arbiter.sv */
/*
 * round-robin arbiter.
 * Combinational one-hot grant to the first requester at or after the
 * priority pointer; the pointer moves past the winner at the next edge.
 */

module spm_rr_arbiter import spm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rstn_i,
  input  logic [N_MASTERS-1:0] req_i,     // one bit per requester.
  output logic [N_MASTERS-1:0] gnt_o,     // one-hot or zero.
  output logic [ID_W-1:0]      gnt_id_o   // index of the winner.
);

  logic [ID_W-1:0] ptr_q;  // highest priority requester.
  logic [ID_W-1:0] ptr_d;
  logic            found;  // some requester won.

  // scan from the pointer, wrapping around.
  always_comb begin
    int unsigned cand;
    cand     = 0;
    found    = 1'b0;
    gnt_o    = '0;
    gnt_id_o = '0;
    for (int k = 0; k < N_MASTERS; k++) begin
      cand = (int'(ptr_q) + k) % N_MASTERS;
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        gnt_o[cand] = 1'b1;
        gnt_id_o    = ID_W'(cand);
      end
    end
  end

  // next pointer is the master after the winner.
  always_comb begin
    ptr_d = ptr_q;
    if (found) begin
      ptr_d = ID_W'((int'(gnt_id_o) + 1) % N_MASTERS);
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      ptr_q <= '0;  // requester 0 first after reset.
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule : spm_rr_arbiter

/* design/spm_xbar.sv */
/*
 * scratchpad crossbar.
 * Decodes each requester's address into bank and word index, arbitrates
 * per bank, returns grants to the winners, and steers bank answers back
 * to the requester named by the registered id.
 */

module spm_xbar import spm_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  tcdm_req_t [N_MASTERS-1:0] mst_req_i,   // requester channels.
  output tcdm_rsp_t [N_MASTERS-1:0] mst_rsp_o,   // grants and answers.
  output bank_req_t [N_BANKS-1:0]   bank_req_o,  // to the banks.
  input  bank_rsp_t [N_BANKS-1:0]   bank_rsp_i   // from the banks.
);

  logic [N_MASTERS-1:0][BANK_SEL_W-1:0] bank_sel;  // decoded bank per requester.
  logic [N_MASTERS-1:0][WORD_IDX_W-1:0] word_idx;  // decoded word per requester.
  logic [N_BANKS-1:0][N_MASTERS-1:0]    arb_req;   // who wants each bank.
  logic [N_BANKS-1:0][N_MASTERS-1:0]    arb_gnt;   // who got each bank.
  logic [N_BANKS-1:0][ID_W-1:0]         arb_id;    // winner per bank.

  // address decode.
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      bank_sel[m] = mst_req_i[m].addr[BANK_LSB +: BANK_SEL_W];
      word_idx[m] = mst_req_i[m].addr[IDX_LSB +: WORD_IDX_W];
    end
  end

  // per bank request vectors.
  always_comb begin
    arb_req = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      for (int m = 0; m < N_MASTERS; m++) begin
        arb_req[b][m] = mst_req_i[m].req && (bank_sel[m] == BANK_SEL_W'(b));
      end
    end
  end

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_arb
    spm_rr_arbiter i_arbiter (
      .clk_i    ( clk_i      ),
      .rstn_i   ( rstn_i     ),
      .req_i    ( arb_req[b] ),
      .gnt_o    ( arb_gnt[b] ),
      .gnt_id_o ( arb_id[b]  )
    );
  end

  // winner's fields go to the bank.
  always_comb begin
    for (int b = 0; b < N_BANKS; b++) begin
      bank_req_o[b].req   = |arb_gnt[b];                 // banks are always ready.
      bank_req_o[b].we    = mst_req_i[arb_id[b]].we;
      bank_req_o[b].idx   = word_idx[arb_id[b]];
      bank_req_o[b].be    = mst_req_i[arb_id[b]].be;
      bank_req_o[b].wdata = mst_req_i[arb_id[b]].wdata;
      bank_req_o[b].id    = arb_id[b];
    end
  end

  // grant return and response routing.
  always_comb begin
    mst_rsp_o = '0;
    for (int m = 0; m < N_MASTERS; m++) begin
      for (int b = 0; b < N_BANKS; b++) begin
        if (arb_gnt[b][m]) begin
          mst_rsp_o[m].gnt = 1'b1;  // at most one bank per requester.
        end
        // one request in flight per requester, so at most one bank matches.
        if (bank_rsp_i[b].r_valid && (bank_rsp_i[b].r_id == ID_W'(m))) begin
          mst_rsp_o[m].r_valid = 1'b1;
          mst_rsp_o[m].r_data  = bank_rsp_i[b].r_data;
        end
      end
    end
  end

endmodule : spm_xbar

/* design/spm_subsystem.sv */
/*
 * scratchpad subsystem top.
 * Two requesters reach four interleaved sram banks through the crossbar.
 */

module spm_subsystem import spm_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  tcdm_req_t [N_MASTERS-1:0] mst_req_i,  // requester channels.
  output tcdm_rsp_t [N_MASTERS-1:0] mst_rsp_o   // grants and answers.
);

  bank_req_t [N_BANKS-1:0] bank_req;  // crossbar to banks.
  bank_rsp_t [N_BANKS-1:0] bank_rsp;  // banks to crossbar.

  spm_xbar i_xbar (
    .clk_i      ( clk_i     ),
    .rstn_i     ( rstn_i    ),
    .mst_req_i  ( mst_req_i ),
    .mst_rsp_o  ( mst_rsp_o ),
    .bank_req_o ( bank_req  ),
    .bank_rsp_i ( bank_rsp  )
  );

  l1_spm i_l1_spm (
    .clk_i      ( clk_i    ),
    .rstn_i     ( rstn_i   ),
    .bank_req_i ( bank_req ),
    .bank_rsp_o ( bank_rsp )
  );

endmodule : spm_subsystem

/* tests/tb_spm_subsystem.sv */
/*
 * spm subsystem testbench.
 * Replays request lines from the case file on both requesters, keeps a
 * reference word memory and a round-robin model per bank, and checks
 * grants, grant order and every response against them.
 */

module tb_spm_subsystem import spm_pkg::*; ();

  // one line of the case file.
  typedef struct packed {
    logic [ID_W-1:0]   mst;    // requester number.
    logic              we;     // 1 = write.
    logic [ADDR_W-1:0] addr;   // byte address.
    logic [BE_W-1:0]   be;     // byte enables.
    logic [DATA_W-1:0] wdata;  // write data.
    logic [7:0]        grp;    // lines of one group start together.
    logic [DATA_W-1:0] exp;    // expected read data.
  } case_t;

  logic                      clk_i;
  logic                      rstn_i;
  tcdm_req_t [N_MASTERS-1:0] mst_req;  // driven 1 unit after the edge.
  tcdm_rsp_t [N_MASTERS-1:0] mst_rsp;

  case_t             cases[$];                         // all case lines.
  logic [DATA_W-1:0] ref_mem [N_BANKS*N_WORDS];        // reference words.
  int                rr_ptr [N_BANKS];                 // reference priority.
  int                cyc_cnt;
  int                cycle_limit;

  spm_subsystem uut (
    .clk_i     ( clk_i   ),
    .rstn_i    ( rstn_i  ),
    .mst_req_i ( mst_req ),
    .mst_rsp_o ( mst_rsp )
  );

  always #5 clk_i = ~clk_i;  // period 10.

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_rsp(input int m, input tcdm_rsp_t got, input tcdm_rsp_t exp,
                           input bit data_valid);
    if (got.r_valid !== exp.r_valid) begin
      report_fail($sformatf("[FAIL] mst_rsp_o[%0d].r_valid got %h exp %h",
                            m, got.r_valid, exp.r_valid));
    end
    if (data_valid && (got.r_data !== exp.r_data)) begin
      report_fail($sformatf("[FAIL] mst_rsp_o[%0d].r_data got %h exp %h",
                            m, got.r_data, exp.r_data));
    end
  endtask

  task automatic check_gnt_order(input int bank, input logic [ID_W-1:0] got,
                                 input logic [ID_W-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("[FAIL] bank%0d gnt_id got %h exp %h", bank, got, exp));
    end
  endtask

  // reference memory slot is {word index, bank}.
  function automatic logic [7:0] model_index(input logic [ADDR_W-1:0] addr);
    return addr[IDX_LSB+WORD_IDX_W-1:BANK_LSB];
  endfunction

  task automatic apply_write(input logic [7:0] i, input logic [BE_W-1:0] be,
                             input logic [DATA_W-1:0] wdata);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        ref_mem[i][b*8 +: 8] = wdata[b*8 +: 8];  // enabled bytes only.
      end
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    int          row;
    string       line;
    logic [31:0] t_mst;
    logic [31:0] t_we;
    logic [31:0] t_addr;
    logic [31:0] t_be;
    logic [31:0] t_wdata;
    logic [31:0] t_grp;
    logic [31:0] t_exp;
    fd = $fopen("tests/spm_cases.txt", "r");
    if (fd == 0) begin
      report_fail("could not open tests/spm_cases.txt");
    end
    row = 0;
    while ($fgets(line, fd) != 0) begin
      row++;
      if (line.len() > 0 && line.getc(0) != "#") begin  // skip column notes.
        n = $sscanf(line, "%h %h %h %h %h %h %h",
                    t_mst, t_we, t_addr, t_be, t_wdata, t_grp, t_exp);
        if (n > 0) begin
          if (n != 7 || t_mst >= N_MASTERS) begin
            report_fail($sformatf("case file line %0d is malformed", row));
          end
          cases.push_back('{mst: t_mst[ID_W-1:0], we: t_we[0], addr: t_addr,
                            be: t_be[BE_W-1:0], wdata: t_wdata, grp: t_grp[7:0],
                            exp: t_exp});
        end
      end
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      report_fail("the case file holds no requests");
    end
    cycle_limit = 4 * cases.size() + 50;  // four cycles per line plus margin.
  endtask

  // idle cycles show no grant and no response.
  task automatic idle_check(input int n);
    repeat (n) begin
      @(negedge clk_i);
      for (int m = 0; m < N_MASTERS; m++) begin
        check_rsp(m, mst_rsp[m], '0, 1'b1);
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  // drives one requester through its lines of group g.
  task automatic run_master(input int m, input int g);
    int        sel[$];
    int        k;
    int        waits;
    bit        pend;       // response due this cycle.
    bit        pend_rd;
    case_t     c;
    tcdm_rsp_t exp_rsp;
    logic [DATA_W-1:0] pend_data;
    for (int i = 0; i < cases.size(); i++) begin
      if (cases[i].mst == ID_W'(m) && cases[i].grp == 8'(g)) begin
        sel.push_back(i);
      end
    end
    k     = 0;
    waits = 0;
    pend  = 1'b0;
    pend_rd   = 1'b0;
    pend_data = '0;
    while (k < sel.size() || pend) begin
      if (k < sel.size()) begin
        c = cases[sel[k]];
        mst_req[m] = '{req: 1'b1, we: c.we, addr: c.addr, be: c.be, wdata: c.wdata};
      end else begin
        mst_req[m] = '0;  // drop req once all lines are sent.
      end
      @(negedge clk_i);
      exp_rsp = '0;
      if (pend) begin
        exp_rsp.r_valid = 1'b1;
        exp_rsp.r_data  = pend_data;
      end
      check_rsp(m, mst_rsp[m], exp_rsp, pend && pend_rd);
      pend = 1'b0;
      if (k < sel.size()) begin
        if (mst_rsp[m].gnt) begin  // accepted at the coming edge.
          pend    = 1'b1;
          pend_rd = !c.we;
          waits   = 0;
          if (c.we) begin
            apply_write(model_index(c.addr), c.be, c.wdata);
          end else begin
            pend_data = ref_mem[model_index(c.addr)];
            if (pend_data !== c.exp) begin
              report_fail($sformatf("[FAIL] case %0d exp_rdata file %h model %h",
                                    sel[k], c.exp, pend_data));
            end
          end
          k++;
        end else begin
          waits++;
          if (waits > 1) begin
            report_fail($sformatf("requester %0d waited more than one cycle for a grant", m));
          end
        end
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  // round-robin reference model per bank.
  always @(negedge clk_i) begin : arb_monitor
    logic [N_MASTERS-1:0] want;
    logic [ID_W-1:0]      got_id;
    logic [ID_W-1:0]      exp_id;
    int unsigned          cand;
    int                   n_gnt;
    bit                   found;
    if (!rstn_i) begin
      for (int b = 0; b < N_BANKS; b++) begin
        rr_ptr[b] = 0;  // requester 0 first.
      end
    end else begin
      for (int m = 0; m < N_MASTERS; m++) begin
        if (mst_rsp[m].gnt && !mst_req[m].req) begin
          report_fail($sformatf("[FAIL] mst_rsp_o[%0d].gnt got %h exp %h", m, 1'b1, 1'b0));
        end
      end
      for (int b = 0; b < N_BANKS; b++) begin
        want   = '0;
        n_gnt  = 0;
        got_id = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
          if (mst_req[m].req && mst_req[m].addr[BANK_LSB +: BANK_SEL_W] == BANK_SEL_W'(b)) begin
            want[m] = 1'b1;
            if (mst_rsp[m].gnt) begin
              n_gnt++;
              got_id = ID_W'(m);
            end
          end
        end
        if (want != '0) begin
          found  = 1'b0;
          exp_id = '0;
          for (int k = 0; k < N_MASTERS; k++) begin
            cand = (rr_ptr[b] + k) % N_MASTERS;  // scan from the pointer.
            if (!found && want[cand]) begin
              found  = 1'b1;
              exp_id = ID_W'(cand);
            end
          end
          if (n_gnt != 1) begin
            report_fail($sformatf("bank %0d gave %0d grants while requested", b, n_gnt));
          end
          check_gnt_order(b, got_id, exp_id);
          rr_ptr[b] = (int'(exp_id) + 1) % N_MASTERS;  // past the winner.
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cyc_cnt = cyc_cnt + 1;
    if (cyc_cnt >= cycle_limit) begin
      report_fail($sformatf("timeout after %0d cycles with requests still open", cyc_cnt));
    end
  end

  initial begin
    int max_grp;
    clk_i    = 1'b0;
    rstn_i   = 1'b0;
    mst_req  = '0;
    cyc_cnt  = 0;
    for (int w = 0; w < N_BANKS*N_WORDS; w++) begin
      ref_mem[w] = '1;  // unwritten words read as all ones.
    end
    load_cases();
    max_grp = 0;
    foreach (cases[i]) begin
      if (int'(cases[i].grp) > max_grp) begin
        max_grp = int'(cases[i].grp);
      end
    end
    repeat (2) @(posedge clk_i);
    #1;
    rstn_i = 1'b1;
    idle_check(3);
    for (int g = 0; g <= max_grp; g++) begin
      fork
        run_master(0, g);
        run_master(1, g);
      join
    end
    idle_check(2);
    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_spm_subsystem

/* tests/spm_cases.txt */
# columns: requester we addr be wdata group exp_rdata, all in hex
# we=1 is a write, we=0 a read; exp_rdata is checked for reads only
0 0 00000100 f 00000000 0 ffffffff
1 0 000002c8 f 00000000 0 ffffffff
0 1 00000040 f 12345678 1 00000000
0 0 00000043 f 00000000 1 12345678
0 0 fffffc40 f 00000000 1 12345678
1 1 00000084 f aabbccdd 2 00000000
1 1 00000084 5 11223344 2 00000000
1 0 00000084 f 00000000 2 aa22cc44
1 1 00000084 a 55667788 2 00000000
1 0 00000084 f 00000000 2 55227744
0 1 00000108 1 000000a5 2 00000000
0 0 00000108 f 00000000 2 ffffffa5
0 1 00000018 f cafef00d 3 00000000
1 1 00000014 f 0badbeef 3 00000000
0 0 00000014 f 00000000 4 0badbeef
1 0 00000018 f 00000000 4 cafef00d
0 1 0000020c f 00000001 5 00000000
0 0 0000021c f 00000000 5 00000002
0 0 0000020c f 00000000 5 00000001
1 1 0000021c f 00000002 5 00000000
1 0 0000020c f 00000000 5 00000001
1 0 0000021c f 00000000 5 00000002
1 0 abcdf043 f 00000000 6 12345678
0 0 00000204 f 00000000 6 ffffffff

/* spm_subsystem.f */
design/spm_pkg.sv
design/spm_sram_bank.sv
design/l1_spm.sv
design/spm_rr_arbiter.sv
design/spm_xbar.sv
design/spm_subsystem.sv
tests/tb_spm_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the spm subsystem testbench with Verilator.
# Exit status is nonzero when the build fails, the run fails or the log
# holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_spm_subsystem

verilator --binary --timing -j 0 \
  --top-module tb_spm_subsystem \
  -f spm_subsystem.f \
  -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
